/* flist.f */
+incdir+include
design/fds_bus_pkg.sv
design/fds_disk_pkg.sv
design/fds_reg_decode.sv
design/fds_timer_irq.sv
design/fds_disk_port.sv
design/fds_prg_map.sv
design/fds_mapper_top.sv
dv/fds_assertions.sv
dv/fds_tb.sv

/* Makefile */
# tool, flags, top module and file list
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/10ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/10ps
TOP        = fds_tb
FLIST      = flist.f
PASS_MSG   = TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* dv/fds_vectors.txt */
# op addr data expected, all hex. W write strobe, R read strobe (expected = bus_drive<<8 | rdata)
# S strobes at 0 (data = count), Q wait irq (data = timeout, expected = strobes), M strobe with
# chr_addr = data (expected = chr_a10<<24 | ram_addr), P pins (data = diskside<<2 | eject<<1 | busy),
# D diskside_auto
D 0000 0000 00000000
# status readback
P 0000 0003 00000000
R 4033 0000 00000180
R 4029 0000 00000100
R 4032 0000 00000105
P 0000 0000 00000000
R 4029 0000 00000101
R 4032 0000 00000100
R 5000 0000 00000000
# one-shot timer, N = 5
W 4020 0005 00000000
W 4021 0000 00000000
W 4023 0001 00000000
W 4022 0002 00000000
Q 0000 0020 00000006
S 0000 0005 00000000
R 4030 0000 00000101
S 0000 000c 00000000
R 4030 0000 00000100
# repeat timer, the acknowledge read is one of the N+1 strobes of a period
W 4022 0003 00000000
Q 0000 0020 00000006
R 4030 0000 00000101
Q 0000 0020 00000005
R 4030 0000 00000101
# master enable cleared
W 4023 0000 00000000
W 4022 0002 00000000
S 0000 000a 00000000
R 4030 0000 00000100
# disk read on side 1, offset 16 + 65500 = ffec
P 0000 0004 00000000
R f4d0 0000 000001ec
R f4d1 0000 000001ff
M e000 0000 003ce000
R f4d0 0000 000001ed
W 4025 0002 00000000
R f4d0 0000 000001ec
# saved flag through a write transfer
R 4208 0000 00000100
W 4025 0000 00000000
R f4cd 0000 000001ec
R f4ce 0000 000001ff
S 0000 0001 00000000
R 4208 0000 00000101
# bank map, mirroring and side register
M 6000 0000 0000e000
M e000 0000 00000000
W 4025 0000 00000000
M 6000 2400 0100e000
M 6000 2800 0000e000
W 4025 0008 00000000
M 6000 2400 0000e000
M 6000 2800 0100e000
D 0000 0000 00000000
W 4027 0002 00000000
D 0000 0000 00000002

/* dv/fds_tb.sv */
// mapper testbench; replays dv/fds_vectors.txt against the top level and prints a closing report
`timescale 1ns/10ps

module fds_tb;

	logic                      clk20;
	logic                      reset;
	fds_bus_pkg::fds_cpu_bus_t cpu;
	logic [7:0]                ram_rdata;
	logic [13:0]               chr_addr;
	logic [1:0]                diskside;
	logic                      fds_busy;
	logic                      fds_eject;
	logic [7:0]                rdata;
	logic                      bus_drive;
	logic                      prg_allow;
	logic [21:0]               ram_addr;
	logic                      chr_a10;
	logic                      ciram_ce;
	logic                      irq;
	logic [1:0]                diskside_auto;

	int unsigned mismatches;
	int unsigned failures;  // timeouts, file and format problems
	int          line_no;

	fds_mapper_top dut (.*);

	initial begin
		clk20 = 1'b0;
		forever #2 clk20 = ~clk20;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("[FAIL] %s = 0x%h, expected 0x%h (vector line %0d)", name, got, exp, line_no);
		end
	endtask

	// reads in 6000-FFFF reach PRG unless the mapper drives the data port
	function automatic logic prg_read_allowed(input logic [15:0] addr, input logic driven);
		return (addr >= 16'h6000) && !driven;
	endfunction

	// one clk20 with cycle high; returns mid cycle so outputs can be sampled
	task automatic strobe_start(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		ram_rdata = 8'($urandom);
		cpu.cycle = 1'b1;
		cpu.write = wr;
		cpu.addr  = addr;
		cpu.wdata = data;
		@(negedge clk20);
	endtask

	task automatic strobe_end();
		int unsigned gap;
		gap = 1 + $urandom % 4;  // idle clocks to the next CPU cycle
		@(posedge clk20);
		#1;
		cpu.cycle = 1'b0;
		cpu.write = 1'b0;
		repeat (gap) begin
			@(posedge clk20);
			#1;
		end
	endtask

	task automatic wait_irq(input int unsigned limit, input logic [31:0] expect_n);
		int unsigned n;
		n = 0;
		while (!irq && n < limit) begin
			strobe_start(1'b0, 16'h0000, 8'h00);
			strobe_end();
			n++;
		end
		if (!irq) begin
			failures++;
			$display("irq did not rise within %0d strobes (vector line %0d)", limit, line_no);
		end else
			check("irq strobe count", n, expect_n);
	endtask

	task automatic run_vector(input logic [7:0] op, input logic [15:0] addr,
	                          input logic [15:0] data, input logic [31:0] exp);
		case (op)
			"W": begin
				strobe_start(1'b1, addr, data[7:0]);
				strobe_end();
			end
			"R": begin
				strobe_start(1'b0, addr, 8'h00);
				check("bus_drive", 32'(bus_drive), 32'(exp[8]));
				if (exp[8])
					check("rdata", 32'(rdata), 32'(exp[7:0]));
				else
					check("rdata", 32'(rdata), 32'(ram_rdata));  // passthrough
				check("prg_allow", 32'(prg_allow), 32'(prg_read_allowed(addr, exp[8])));
				strobe_end();
			end
			"S": repeat (data) begin
				strobe_start(1'b0, 16'h0000, 8'h00);
				strobe_end();
			end
			"Q": wait_irq(32'(data), exp);
			"M": begin
				chr_addr = data[13:0];
				strobe_start(1'b0, addr, 8'h00);
				check("ram_addr", 32'(ram_addr), 32'(exp[21:0]));
				check("chr_a10", 32'(chr_a10), 32'(exp[24]));
				check("ciram_ce", 32'(ciram_ce), 32'(chr_addr >= 14'h2000));  // nametable range
				check("prg_allow", 32'(prg_allow), 32'(prg_read_allowed(addr, 1'b0)));
				strobe_end();
			end
			"P": begin
				fds_busy  = data[0];
				fds_eject = data[1];
				diskside  = data[3:2];
			end
			"D": check("diskside_auto", 32'(diskside_auto), exp);
			default: begin
				failures++;
				$display("unknown operation in vector line %0d", line_no);
			end
		endcase
	endtask

	initial begin
		int          fd;
		int          n;
		string       text;
		logic [7:0]  op;
		logic [15:0] addr;
		logic [15:0] data;
		logic [31:0] exp;
		void'($urandom(32'h7142));
		mismatches = 0;
		failures   = 0;
		line_no    = 0;
		reset      = 1'b1;
		cpu        = '0;
		ram_rdata  = 8'h00;
		chr_addr   = 14'h0000;
		diskside   = 2'd0;
		fds_busy   = 1'b0;
		fds_eject  = 1'b0;
		repeat (8) @(posedge clk20);
		#1;
		reset = 1'b0;

		fd = $fopen("dv/fds_vectors.txt", "r");
		if (fd == 0) begin
			failures++;
			$display("could not open the vector file dv/fds_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				line_no++;
				if (n > 1 && text.getc(0) != "#") begin  // skip comments and blank lines
					n = $sscanf(text, "%c %h %h %h", op, addr, data, exp);
					if (n == 4)
						run_vector(op, addr, data, exp);
					else begin
						failures++;
						$display("vector line %0d does not have four fields", line_no);
					end
				end
			end
			$fclose(fd);
		end

		$display("run finished: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* dv/fds_assertions.sv */
// concurrent checks on the mapper top level, attached to every fds_mapper_top by the bind below
`timescale 1ns/10ps

module fds_assertions (
	input logic                      clk20,
	input logic                      reset,
	input fds_bus_pkg::fds_cpu_bus_t cpu,
	input logic                      irq,
	input logic                      bus_drive,
	input logic [21:0]               ram_addr,
	input logic [1:0]                diskside_auto,
	input logic                      side_wr,
	input logic                      transfer_active
);

	irq_low_in_reset: assert property (@(posedge clk20) reset && $past(reset) |-> !irq)
		else $error("irq high while reset is applied");

	// no register lives below 4000
	no_drive_low_addr: assert property (@(posedge clk20) cpu.addr < 16'h4000 |-> !bus_drive)
		else $error("bus_drive high for an address below 0x4000");

	// disk bank only in the E000 region during a transfer, bits 21..18 all ones then
	ram_addr_top_bits: assert property (@(posedge clk20)
		ram_addr[21:18] == {4{cpu.addr[15:13] == 3'b111 && transfer_active}})
		else $error("ram_addr bits 21..18 do not match the bank region");

	side_cleared_by_reset: assert property (@(posedge clk20) $past(reset) |-> diskside_auto == 2'd0)
		else $error("diskside_auto not cleared by reset");

	// only a side register write may move it
	side_held_until_write: assert property (@(posedge clk20) disable iff (reset)
		!$past(reset) && !$past(side_wr) |-> $stable(diskside_auto))
		else $error("diskside_auto changed without a write");

endmodule

bind fds_mapper_top fds_assertions u_assertions (
	.clk20           (clk20),
	.reset           (reset),
	.cpu             (cpu),
	.irq             (irq),
	.bus_drive       (bus_drive),
	.ram_addr        (ram_addr),
	.diskside_auto   (diskside_auto),
	.side_wr         (sel.side_wr),
	.transfer_active (disk.transfer_active)
);

/* design/fds_mapper_top.sv */
// disk-system mapper top level; ties the decode, timer, disk port and bank map together
`timescale 1ns/10ps

module fds_mapper_top (
	input  logic                      clk20,
	input  logic                      reset,
	input  fds_bus_pkg::fds_cpu_bus_t cpu,
	input  logic [7:0]                ram_rdata,
	input  logic [13:0]               chr_addr,
	input  logic [1:0]                diskside,
	input  logic                      fds_busy,
	input  logic                      fds_eject,
	output logic [7:0]                rdata,
	output logic                      bus_drive,
	output logic                      prg_allow,
	output logic [21:0]               ram_addr,
	output logic                      chr_a10,
	output logic                      ciram_ce,
	output logic                      irq,
	output logic [1:0]                diskside_auto
);

	fds_bus_pkg::fds_reg_sel_t      sel;
	fds_disk_pkg::fds_disk_status_t disk;

	fds_reg_decode u_decode (
		.cpu (cpu),
		.sel (sel)
	);

	fds_timer_irq u_timer (
		.clk20 (clk20),
		.reset (reset),
		.cycle (cpu.cycle),
		.sel   (sel),
		.wdata (cpu.wdata),
		.irq   (irq)
	);

	fds_disk_port u_disk (
		.clk20    (clk20),
		.reset    (reset),
		.cycle    (cpu.cycle),
		.sel      (sel),
		.wdata    (cpu.wdata),
		.diskside (diskside),
		.disk     (disk)
	);

	fds_prg_map u_map (
		.clk20 (clk20), .reset (reset),
		.cpu (cpu), .sel (sel), .disk (disk), .irq (irq),
		.ram_rdata (ram_rdata), .chr_addr (chr_addr),
		.fds_busy (fds_busy), .fds_eject (fds_eject),
		.rdata (rdata), .bus_drive (bus_drive), .prg_allow (prg_allow),
		.ram_addr (ram_addr), .chr_a10 (chr_a10), .ciram_ce (ciram_ce),
		.diskside_auto (diskside_auto)
	);

endmodule

/* design/fds_prg_map.sv */
// CPU readback mux, PRG permission and bank map, CHR mirroring and the disk side register
`timescale 1ns/10ps
`include "fds_cfg.svh"

module fds_prg_map (
	input  logic                           clk20,
	input  logic                           reset,
	input  fds_bus_pkg::fds_cpu_bus_t      cpu,
	input  fds_bus_pkg::fds_reg_sel_t      sel,
	input  fds_disk_pkg::fds_disk_status_t disk,
	input  logic                           irq,
	input  logic [7:0]                     ram_rdata,
	input  logic [13:0]                    chr_addr,
	input  logic                           fds_busy,
	input  logic                           fds_eject,
	output logic [7:0]                     rdata,
	output logic                           bus_drive,
	output logic                           prg_allow,
	output logic [21:0]                    ram_addr,
	output logic                           chr_a10,
	output logic                           ciram_ce,
	output logic [1:0]                     diskside_auto
);

	logic       port_lo_rd;
	logic       port_hi_rd;
	logic [5:0] prg_bank;  // ram_addr bits 18..13

	// data port readback only while no transfer owns the port
	assign port_lo_rd = (sel.data_lo_rd | sel.write_lo_rd) & ~disk.transfer_active;
	assign port_hi_rd = (sel.data_hi_rd | sel.write_hi_rd) & ~disk.transfer_active;

	always_comb begin
		bus_drive = 1'b1;
		if (sel.irq_stat_rd)
			rdata = {7'd0, irq};
		else if (sel.drive_stat_rd)
			rdata = {5'd0, fds_eject, disk.disk_end, fds_eject};
		else if (sel.ext_stat_rd)
			rdata = `FDS_EXT_STAT_VALUE;
		else if (sel.saved_rd)
			rdata = {7'd0, disk.saved};
		else if (sel.busy_rd)
			rdata = {7'd0, ~fds_busy};  // zero means busy
		else if (port_lo_rd)
			rdata = disk.rom_offset[7:0];
		else if (port_hi_rd)
			rdata = {3'b111, disk.rom_offset[12:8]};
		else begin
			rdata     = ram_rdata;
			bus_drive = 1'b0;
		end
	end

	// writes to 6000-DFFF or during a transfer, reads from 6000-FFFF except the port
	assign prg_allow = (cpu.write & (disk.transfer_active |
	                                 (cpu.addr[15] ^ (&cpu.addr[14:13])))) |
	                   (~cpu.write & ((cpu.addr[15] & ~port_lo_rd & ~port_hi_rd) |
	                                  (cpu.addr[15:13] == 3'b011)));

	// E000 region: BIOS, or the disk image while a transfer is active
	always_comb begin
		if (cpu.addr[15:13] == 3'b111)
			prg_bank = {1'b1, disk.rom_offset[17:13]} & {6{disk.transfer_active}};
		else
			prg_bank = {4'b0001, cpu.addr[14:13]};  // work RAM
	end

	assign ram_addr = {{3{prg_bank[5]}}, prg_bank, cpu.addr[12:0]};

	// nametable mirroring
	assign chr_a10  = !chr_addr[13] ? chr_addr[10] :
	                  (disk.vertical ? chr_addr[10] : chr_addr[11]);
	assign ciram_ce = chr_addr[13];

	always_ff @(posedge clk20) begin
		if (reset)
			diskside_auto <= 2'd0;
		else if (sel.side_wr)
			diskside_auto <= cpu.wdata[1:0];
	end

endmodule

/* design/fds_disk_port.sv */
// disk transfer port: read and write handshakes, disk pointer, side offset and drive control
`timescale 1ns/10ps
`include "fds_cfg.svh"

module fds_disk_port (
	input  logic                          clk20,
	input  logic                          reset,
	input  logic                          cycle,
	input  fds_bus_pkg::fds_reg_sel_t     sel,
	input  logic [7:0]                    wdata,
	input  logic [1:0]                    diskside,
	output fds_disk_pkg::fds_disk_status_t disk
);

	fds_disk_pkg::fds_xfer_state_e rd_state;
	fds_disk_pkg::fds_xfer_state_e wr_state;
	logic [15:0] disk_pos;
	logic [17:0] side_offset;
	logic        disk_end;
	logic        write_en;
	logic        vertical;
	logic        disk_reset;  // held pointer clear
	logic        saved;

	// header + side bytes * side
	assign side_offset = 18'(`FDS_DISK_HEADER_BYTES) + 18'(`FDS_SIDE_BYTES) * 18'(diskside);
	assign disk_end    = (disk_pos == 16'(`FDS_SIDE_BYTES - 1));

	always_ff @(posedge clk20) begin
		if (reset) begin
			rd_state   <= fds_disk_pkg::xfer_idle;
			wr_state   <= fds_disk_pkg::xfer_idle;
			disk_pos   <= 16'd0;
			write_en   <= 1'b0;
			vertical   <= 1'b0;
			disk_reset <= 1'b0;
			saved      <= 1'b0;
		end else begin
			if (cycle) begin
				if (sel.data_lo_rd)
					rd_state <= fds_disk_pkg::xfer_lo_seen;
				else if (sel.data_hi_rd && rd_state == fds_disk_pkg::xfer_lo_seen)
					rd_state <= fds_disk_pkg::xfer_active;
				else
					rd_state <= fds_disk_pkg::xfer_idle;

				if (sel.write_lo_rd && write_en)
					wr_state <= fds_disk_pkg::xfer_lo_seen;
				else if (sel.write_hi_rd && wr_state == fds_disk_pkg::xfer_lo_seen)
					wr_state <= fds_disk_pkg::xfer_active;
				else
					wr_state <= fds_disk_pkg::xfer_idle;

				if (wr_state == fds_disk_pkg::xfer_active)
					saved <= 1'b1;

				if (disk_reset)
					disk_pos <= 16'd0;
				else if (rd_state == fds_disk_pkg::xfer_active && !disk_end)
					disk_pos <= disk_pos + 16'd1;  // one byte per completed read
			end

			if (sel.disk_ctrl_wr) begin
				disk_reset <= wdata[1];
				write_en   <= ~wdata[2];
				vertical   <= ~wdata[3];
				if (wdata[1])
					disk_pos <= 16'd0;  // clear takes effect on the write itself
			end
		end
	end

	assign disk.rom_offset      = 18'(disk_pos) + side_offset;
	assign disk.disk_end        = disk_end;
	assign disk.transfer_active = (rd_state == fds_disk_pkg::xfer_active) |
	                              (wr_state == fds_disk_pkg::xfer_active);
	assign disk.saved           = saved;
	assign disk.vertical        = vertical;

endmodule

/* design/fds_timer_irq.sv */
// 16-bit timer IRQ with reload latch, repeat mode and master enable, stepped once per CPU strobe
`timescale 1ns/10ps

module fds_timer_irq (
	input  logic                      clk20,
	input  logic                      reset,
	input  logic                      cycle,   // CPU strobe, timer tick
	input  fds_bus_pkg::fds_reg_sel_t sel,
	input  logic [7:0]                wdata,
	output logic                      irq
);

	logic [15:0] timer_latch;
	logic [15:0] timer;
	logic        repeat_mode;
	logic        timer_en;
	logic        reg_en;  // master enable

	always_ff @(posedge clk20) begin
		if (reset) begin
			timer_latch <= 16'd0;
			timer       <= 16'd0;
			repeat_mode <= 1'b0;
			timer_en    <= 1'b0;
			reg_en      <= 1'b0;
			irq         <= 1'b0;
		end else begin
			if (cycle && timer_en) begin
				if (timer == 16'd0) begin
					irq   <= 1'b1;
					timer <= timer_latch;
					if (!repeat_mode)
						timer_en <= 1'b0;  // one-shot stops here
				end else begin
					timer <= timer - 16'd1;
				end
			end

			if (sel.timer_lo_wr)
				timer_latch[7:0] <= wdata;
			if (sel.timer_hi_wr)
				timer_latch[15:8] <= wdata;

			// register writes override the count above
			if (sel.timer_ctrl_wr) begin
				repeat_mode <= wdata[0];
				timer_en    <= wdata[1] & reg_en;
				if (wdata[1] && reg_en)
					timer <= timer_latch;
				else
					irq <= 1'b0;
			end

			if (sel.reg_en_wr) begin
				reg_en <= wdata[0];
				if (!wdata[0]) begin
					timer_en <= 1'b0;
					irq      <= 1'b0;
				end
			end

			if (sel.irq_stat_rd)
				irq <= 1'b0;  // acknowledge by status read
		end
	end

endmodule

/* design/fds_reg_decode.sv */
// address decode of the mapper registers; one select flag per access for the other blocks
`timescale 1ns/10ps
`include "fds_cfg.svh"

module fds_reg_decode (
	input  fds_bus_pkg::fds_cpu_bus_t cpu,
	output fds_bus_pkg::fds_reg_sel_t sel
);

	logic wr;
	logic rd;

	assign wr = cpu.cycle & cpu.write;
	assign rd = cpu.cycle & ~cpu.write;

	// write side
	assign sel.timer_lo_wr   = wr & (cpu.addr == `FDS_TIMER_LO_ADDR);
	assign sel.timer_hi_wr   = wr & (cpu.addr == `FDS_TIMER_HI_ADDR);
	assign sel.timer_ctrl_wr = wr & (cpu.addr == `FDS_TIMER_CTRL_ADDR);
	assign sel.reg_en_wr     = wr & (cpu.addr == `FDS_REG_EN_ADDR);
	assign sel.disk_ctrl_wr  = wr & (cpu.addr == `FDS_DISK_CTRL_ADDR);
	assign sel.side_wr       = wr & (cpu.addr == `FDS_SIDE_ADDR);

	// status reads
	assign sel.irq_stat_rd   = rd & (cpu.addr == `FDS_IRQ_STAT_ADDR);
	assign sel.drive_stat_rd = rd & (cpu.addr == `FDS_DRIVE_STAT_ADDR);
	assign sel.ext_stat_rd   = rd & (cpu.addr == `FDS_EXT_STAT_ADDR);
	assign sel.saved_rd      = rd & (cpu.addr == `FDS_SAVED_ADDR);
	assign sel.busy_rd       = rd & (cpu.addr == `FDS_BUSY_ADDR);

	// data port, both directions are driven by CPU reads
	assign sel.data_lo_rd    = rd & (cpu.addr == `FDS_READ_LO_ADDR);
	assign sel.data_hi_rd    = rd & (cpu.addr == `FDS_READ_HI_ADDR);
	assign sel.write_lo_rd   = rd & (cpu.addr == `FDS_WRITE_LO_ADDR);
	assign sel.write_hi_rd   = rd & (cpu.addr == `FDS_WRITE_HI_ADDR);

endmodule

/* design/fds_disk_pkg.sv */
// disk transfer side types: handshake states and the status bundle of the disk port
package fds_disk_pkg;

	// two-step handshake at the low then high data port address
	typedef enum logic [1:0] {
		xfer_idle,
		xfer_lo_seen,
		xfer_active
	} fds_xfer_state_e;

	typedef struct packed {
		logic [17:0] rom_offset;       // pointer plus side offset into the image
		logic        disk_end;         // pointer at last byte of side
		logic        transfer_active;  // either machine in xfer_active
		logic        saved;
		logic        vertical;         // mirroring select
	} fds_disk_status_t;

endpackage

/* design/fds_bus_pkg.sv */
// CPU bus side types: one bus cycle and the decoded register selects built from it
package fds_bus_pkg;

	// one CPU bus cycle as seen on clk20
	typedef struct packed {
		logic        cycle;  // one clk20 per CPU cycle
		logic        write;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} fds_cpu_bus_t;

	// per-register access flags, qualified with cycle and direction
	typedef struct packed {
		logic timer_lo_wr;
		logic timer_hi_wr;
		logic timer_ctrl_wr;
		logic reg_en_wr;
		logic disk_ctrl_wr;
		logic side_wr;
		logic irq_stat_rd;
		logic drive_stat_rd;
		logic ext_stat_rd;
		logic saved_rd;
		logic busy_rd;
		logic data_lo_rd;   // read port low byte
		logic data_hi_rd;
		logic write_lo_rd;  // write port low byte, also a CPU read
		logic write_hi_rd;
	} fds_reg_sel_t;

endpackage

/* include/fds_cfg.svh */
// mapper register map and disk geometry, included by the decode, disk port and bank map blocks
`ifndef FDS_CFG_SVH
`define FDS_CFG_SVH

// timer and control registers, CPU write side
`define FDS_TIMER_LO_ADDR    16'h4020
`define FDS_TIMER_HI_ADDR    16'h4021
`define FDS_TIMER_CTRL_ADDR  16'h4022
`define FDS_REG_EN_ADDR      16'h4023
`define FDS_DISK_CTRL_ADDR   16'h4025
`define FDS_SIDE_ADDR        16'h4027  // extra register, disk side select

// status registers, CPU read side
`define FDS_IRQ_STAT_ADDR    16'h4030
`define FDS_DRIVE_STAT_ADDR  16'h4032
`define FDS_EXT_STAT_ADDR    16'h4033
`define FDS_SAVED_ADDR       16'h4208
`define FDS_BUSY_ADDR        16'h4029

// disk data port, read in pairs by the patched BIOS
`define FDS_READ_LO_ADDR     16'hF4D0
`define FDS_READ_HI_ADDR     16'hF4D1
`define FDS_WRITE_LO_ADDR    16'hF4CD
`define FDS_WRITE_HI_ADDR    16'hF4CE

`define FDS_DISK_HEADER_BYTES 16     // image header ahead of side 0
`define FDS_SIDE_BYTES        65500  // bytes per disk side

`define FDS_EXT_STAT_VALUE    8'h80

`endif
